// File: Makefile
# Verilator flow for the pulse shaper

VERILATOR ?= verilator
TOP       ?= pulseShaperTb
SEED      ?= 66
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSeed=$(SEED)

# the binary exits non-zero when the testbench stops on $$fatal
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSeed=$(SEED) -Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: hw/foldedAdderTree.sv
`timescale 1ns/1ps

module foldedAdderTree (
	input  logic                    sys_clk,
	input  logic                    reset,
	input  logic                    sam_clk_en,
	input  pulseShaperPkg::sample_t leadProducts [pulseShaperPkg::LeadTaps],
	input  pulseShaperPkg::sample_t trailProducts [pulseShaperPkg::TrailTaps],
	output pulseShaperPkg::sample_t y
);

	// values held in each registered level
	localparam int Lvl1Size = pulseShaperPkg::CenterTap + 1;
	localparam int Lvl2Size = (Lvl1Size + 1) / 2;
	localparam int Lvl3Size = (Lvl2Size + 1) / 2;
	localparam int Lvl4Size = (Lvl3Size + 1) / 2;

	pulseShaperPkg::sample_t sumLvl1 [Lvl1Size];
	pulseShaperPkg::sample_t sumLvl2 [Lvl2Size];
	pulseShaperPkg::sample_t sumLvl3 [Lvl3Size];
	pulseShaperPkg::sample_t sumLvl4 [Lvl4Size];

	// level 1 folds tap i with tap 20-i
	// tap 20-i sits at local index 9-i of the trailing bank
	// centre product passes through alone in the last slot
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			for (int i = 0; i < Lvl1Size; i++) begin
				sumLvl1[i] <= '0;
			end
		end else if (sam_clk_en) begin
			for (int i = 0; i < pulseShaperPkg::CenterTap; i++) begin
				sumLvl1[i] <= leadProducts[i] +
				              trailProducts[pulseShaperPkg::TrailTaps - 1 - i];
			end
			sumLvl1[Lvl1Size-1] <= leadProducts[pulseShaperPkg::CenterTap];
		end
	end

	// level 2, odd leftover carried through
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			for (int i = 0; i < Lvl2Size; i++) begin
				sumLvl2[i] <= '0;
			end
		end else if (sam_clk_en) begin
			for (int i = 0; i < Lvl1Size / 2; i++) begin
				sumLvl2[i] <= sumLvl1[2*i] + sumLvl1[2*i+1];
			end
			if (Lvl1Size % 2 != 0) begin
				sumLvl2[Lvl2Size-1] <= sumLvl1[Lvl1Size-1];
			end
		end
	end

	// level 3
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			for (int i = 0; i < Lvl3Size; i++) begin
				sumLvl3[i] <= '0;
			end
		end else if (sam_clk_en) begin
			for (int i = 0; i < Lvl2Size / 2; i++) begin
				sumLvl3[i] <= sumLvl2[2*i] + sumLvl2[2*i+1];
			end
			if (Lvl2Size % 2 != 0) begin
				sumLvl3[Lvl3Size-1] <= sumLvl2[Lvl2Size-1];
			end
		end
	end

	// level 4
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			for (int i = 0; i < Lvl4Size; i++) begin
				sumLvl4[i] <= '0;
			end
		end else if (sam_clk_en) begin
			for (int i = 0; i < Lvl3Size / 2; i++) begin
				sumLvl4[i] <= sumLvl3[2*i] + sumLvl3[2*i+1];
			end
			if (Lvl3Size % 2 != 0) begin
				sumLvl4[Lvl4Size-1] <= sumLvl3[Lvl3Size-1];
			end
		end
	end

	// output register, sums wrap at the sample width
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			y <= '0;
		end else if (sam_clk_en) begin
			y <= sumLvl4[0] + sumLvl4[1];
		end
	end

endmodule

// File: hw/pulseShaper.sv
`timescale 1ns/1ps

module pulseShaper (
	input  logic                    sys_clk,
	input  logic                    reset,
	input  logic                    sam_clk_en,
	input  pulseShaperPkg::sample_t xIn,
	output pulseShaperPkg::sample_t y
);

	pulseShaperPkg::symCode_t code;
	pulseShaperPkg::symCode_t leadChain;

	pulseShaperPkg::sample_t leadProducts [pulseShaperPkg::LeadTaps];
	pulseShaperPkg::sample_t trailProducts [pulseShaperPkg::TrailTaps];

	// classify once at the input, the delay line carries codes only
	symbolSlicer slicer0 (
		.xIn  (xIn),
		.code (code)
	);

	// taps 0 to 10, centre tap included
	tapBank #(
		.FirstTap (0),
		.BankTaps (pulseShaperPkg::LeadTaps)
	) leadBank (
		.sys_clk    (sys_clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.chainIn    (code),
		.chainOut   (leadChain),
		.products   (leadProducts)
	);

	// taps 11 to 20
	// last code drops off the end of the filter
	tapBank #(
		.FirstTap (pulseShaperPkg::LeadTaps),
		.BankTaps (pulseShaperPkg::TrailTaps)
	) trailBank (
		.sys_clk    (sys_clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.chainIn    (leadChain),
		.chainOut   (),
		.products   (trailProducts)
	);

	foldedAdderTree tree0 (
		.sys_clk       (sys_clk),
		.reset         (reset),
		.sam_clk_en    (sam_clk_en),
		.leadProducts  (leadProducts),
		.trailProducts (trailProducts),
		.y             (y)
	);

endmodule

// File: hw/pulseShaperPkg.sv
package pulseShaperPkg;

	// sample, product and partial sum all share this width
	localparam int SampleWidth = 18;
	typedef logic signed [SampleWidth-1:0] sample_t;

	// filter geometry
	localparam int NumTaps = 21;
	localparam int CenterTap = 10;
	localparam int LeadTaps = CenterTap + 1;
	localparam int TrailTaps = NumTaps - LeadTaps;

	// registered stages from tap contents to y
	// 11 -> 6 -> 3 -> 2 -> y
	localparam int TreeStages = 5;

	// four amplitude levels, lowest first
	localparam int NumLevels = 4;
	localparam int LevelBits = $clog2(NumLevels);

	localparam sample_t levelTable [NumLevels] = '{
		-18'sd98303,
		-18'sd32768,
		18'sd32768,
		18'sd98303
	};

	// half-width of each window, the edges themselves are outside
	localparam int Tolerance = 2;

	// valid low means the sample hit no window
	typedef struct packed {
		logic valid;
		logic [LevelBits-1:0] level;
	} symCode_t;

	// coefficient per tap and level
	// rows mirror about CenterTap, columns follow levelTable
	localparam sample_t tapTable [NumTaps][NumLevels] = '{
		'{-18'sd2732,  -18'sd911,   18'sd911,   18'sd2732},
		'{-18'sd2616,  -18'sd872,   18'sd872,   18'sd2616},
		'{-18'sd646,   -18'sd215,   18'sd215,   18'sd646},
		'{18'sd2371,   18'sd790,    -18'sd790,  -18'sd2371},
		'{18'sd4709,   18'sd1570,   -18'sd1570, -18'sd4709},
		'{18'sd4495,   18'sd1498,   -18'sd1498, -18'sd4495},
		'{18'sd680,    18'sd227,    -18'sd227,  -18'sd680},
		'{-18'sd6270,  -18'sd2090,  18'sd2090,  18'sd6270},
		'{-18'sd14364, -18'sd4788,  18'sd4788,  18'sd14364},
		'{-18'sd20834, -18'sd6945,  18'sd6945,  18'sd20834},
		// centre tap
		'{-18'sd23301, -18'sd7767,  18'sd7767,  18'sd23301},
		'{-18'sd20834, -18'sd6945,  18'sd6945,  18'sd20834},
		'{-18'sd14364, -18'sd4788,  18'sd4788,  18'sd14364},
		'{-18'sd6270,  -18'sd2090,  18'sd2090,  18'sd6270},
		'{18'sd680,    18'sd227,    -18'sd227,  -18'sd680},
		'{18'sd4495,   18'sd1498,   -18'sd1498, -18'sd4495},
		'{18'sd4709,   18'sd1570,   -18'sd1570, -18'sd4709},
		'{18'sd2371,   18'sd790,    -18'sd790,  -18'sd2371},
		'{-18'sd646,   -18'sd215,   18'sd215,   18'sd646},
		'{-18'sd2616,  -18'sd872,   18'sd872,   18'sd2616},
		'{-18'sd2732,  -18'sd911,   18'sd911,   18'sd2732}
	};

endpackage

// File: hw/symbolSlicer.sv
`timescale 1ns/1ps

module symbolSlicer (
	input  pulseShaperPkg::sample_t  xIn,
	output pulseShaperPkg::symCode_t code
);

	// sign-extended copy of the sample
	// keeps the window bounds from wrapping near full scale
	int sample;

	assign sample = int'(xIn);

	// windows never overlap, so at most one level can match
	always_comb begin
		code = '0;
		for (int l = 0; l < pulseShaperPkg::NumLevels; l++) begin
			if ((sample > int'(pulseShaperPkg::levelTable[l]) - pulseShaperPkg::Tolerance) &&
			    (sample < int'(pulseShaperPkg::levelTable[l]) + pulseShaperPkg::Tolerance)) begin
				code.valid = 1'b1;
				code.level = pulseShaperPkg::LevelBits'(l);
			end
		end
	end

	// anything outside every window leaves code at no symbol

endmodule

// File: hw/tapBank.sv
`timescale 1ns/1ps

module tapBank #(
	parameter int FirstTap = 0,
	parameter int BankTaps = 11
) (
	input  logic                     sys_clk,
	input  logic                     reset,
	input  logic                     sam_clk_en,
	input  pulseShaperPkg::symCode_t chainIn,
	output pulseShaperPkg::symCode_t chainOut,
	output pulseShaperPkg::sample_t  products [BankTaps]
);

	// taps[0] is the newest code in this bank
	pulseShaperPkg::symCode_t taps [BankTaps];

	// delay line moves one place per strobe
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			for (int j = 0; j < BankTaps; j++) begin
				taps[j] <= '0;
			end
		end else if (sam_clk_en) begin
			taps[0] <= chainIn;
			for (int j = 1; j < BankTaps; j++) begin
				taps[j] <= taps[j-1];
			end
		end
	end

	// oldest code feeds the next bank
	assign chainOut = taps[BankTaps-1];

	// table lookup stands in for the multiply
	// global tap index is FirstTap plus the local position
	always_comb begin
		for (int j = 0; j < BankTaps; j++) begin
			if (taps[j].valid) begin
				products[j] = pulseShaperPkg::tapTable[FirstTap + j][taps[j].level];
			end else begin
				products[j] = '0;
			end
		end
	end

	// a cleared tap reads as no symbol, so reset also zeroes products

endmodule

// File: project.f
hw/pulseShaperPkg.sv
hw/symbolSlicer.sv
hw/tapBank.sv
hw/foldedAdderTree.sv
hw/pulseShaper.sv
test/pulseShaper_props.sv
test/pulseShaperTb.sv

// File: test/pulseShaperTb.sv
`timescale 1ns/1ps

module pulseShaperTb #(
	parameter int Seed = 66
);

	localparam int ClkPeriod = 8;
	localparam int ResetCycles = 10;
	localparam int MaxGap = 5;
	localparam int MaxLines = 1000;
	localparam int WatchdogCycles = 4000;
	localparam int OpReset = 0;
	localparam int OpStrobe = 1;
	localparam string VectorFile = "test/pulseShaper_vectors.txt";

	logic sys_clk;
	logic reset;
	logic sam_clk_en;
	pulseShaperPkg::sample_t xIn;
	pulseShaperPkg::sample_t y;

	// y must hold the last expected output through idle cycles
	pulseShaperPkg::sample_t lastY;
	int seed;

	pulseShaper dut0 (
		.sys_clk    (sys_clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.xIn        (xIn),
		.y          (y)
	);

	initial begin
		sys_clk = 1'b0;
		forever begin
			#(ClkPeriod / 2) sys_clk = ~sys_clk;
		end
	end

	task automatic abortRun();
		$display(">>> FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkSample(input string name, input pulseShaperPkg::sample_t expected,
			input pulseShaperPkg::sample_t actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
			abortRun();
		end
	endtask

	// strip newline and trailing blanks from a line read by $fgets
	function automatic string trimLine(input string s);
		string t;
		t = s;
		while (t.len() > 0 && (t.getc(t.len() - 1) == 8'h0a ||
		       t.getc(t.len() - 1) == 8'h0d || t.getc(t.len() - 1) == 8'h20)) begin
			t = t.substr(0, t.len() - 2);
		end
		return t;
	endfunction

	// runs one vector line from falling edge to falling edge
	task automatic runStep(input string name, input int op, input int gap,
			input int sampleVal, input int expectVal);
		int idle;
		idle = gap;
		if (idle < 0) begin
			idle = $unsigned($random(seed)) % (MaxGap + 1);
		end else if (idle > MaxGap) begin
			$display("%s asks for a gap of %0d idle cycles, more than allowed", name, idle);
			abortRun();
		end
		// new sample is visible early but only counts on the strobe
		xIn = pulseShaperPkg::sample_t'(sampleVal);
		for (int c = 0; c < idle; c++) begin
			@(negedge sys_clk);
			checkSample($sformatf("%s idle", name), lastY, y);
		end
		if (op == OpReset) begin
			reset = 1'b1;
			@(negedge sys_clk);
			reset = 1'b0;
		end else if (op == OpStrobe) begin
			sam_clk_en = 1'b1;
			@(negedge sys_clk);
			sam_clk_en = 1'b0;
		end else begin
			$display("%s has an unknown operation code %0d", name, op);
			abortRun();
		end
		lastY = pulseShaperPkg::sample_t'(expectVal);
		checkSample(name, lastY, y);
	endtask

	// guards against a hang anywhere in the run
	initial begin
		for (int c = 0; c < WatchdogCycles; c++) begin
			@(posedge sys_clk);
		end
		$display("simulation still running after %0d cycles", WatchdogCycles);
		abortRun();
	end

	initial begin
		int fd;
		int lineNo;
		int stepCount;
		int fields;
		int op;
		int gap;
		int sampleVal;
		int expectVal;
		string line;
		string testName;

		seed = Seed;
		reset = 1'b1;
		sam_clk_en = 1'b0;
		xIn = '0;
		lastY = '0;
		testName = "unnamed";
		lineNo = 0;
		stepCount = 0;

		// y clears on the first reset edge and stays there
		for (int c = 0; c < ResetCycles; c++) begin
			@(negedge sys_clk);
			checkSample("initial reset", '0, y);
		end
		reset = 1'b0;

		fd = $fopen(VectorFile, "r");
		if (fd == 0) begin
			$display("could not open the vector file %s", VectorFile);
			abortRun();
		end

		while (!$feof(fd) && lineNo < MaxLines) begin
			line = "";
			lineNo++;
			if ($fgets(line, fd) == 0) begin
				continue;
			end
			line = trimLine(line);
			if (line.len() == 0 || line.getc(0) == "#") begin
				continue;
			end
			// a line starting with @ names the steps that follow
			if (line.getc(0) == "@") begin
				testName = line.substr(2, line.len() - 1);
				continue;
			end
			fields = $sscanf(line, "%d %d %d %d", op, gap, sampleVal, expectVal);
			if (fields != 4) begin
				$display("line %0d of the vector file does not hold four numbers", lineNo);
				abortRun();
			end
			runStep($sformatf("%s line %0d", testName, lineNo), op, gap, sampleVal, expectVal);
			stepCount++;
		end
		$fclose(fd);

		if (stepCount == 0 || lineNo >= MaxLines) begin
			$display("vector file is empty or longer than %0d lines", MaxLines);
			abortRun();
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

// File: test/pulseShaper_props.sv
`timescale 1ns/1ps

module pulseShaperProps (
	input logic                    sys_clk,
	input logic                    reset,
	input logic                    sam_clk_en,
	input pulseShaperPkg::sample_t y
);

	// reset clears the output register along with the rest
	property clearedAfterReset;
		@(posedge sys_clk) reset |=> (y == '0);
	endproperty

	// output only moves on a strobe
	property holdsWhenIdle;
		@(posedge sys_clk) (!sam_clk_en && !reset) |=> $stable(y);
	endproperty

	resetClears: assert property (clearedAfterReset)
		else $error("y not zero in the cycle after reset");

	idleHolds: assert property (holdsWhenIdle)
		else $error("y changed on a cycle without sam_clk_en");

endmodule

bind pulseShaper pulseShaperProps props0 (
	.sys_clk    (sys_clk),
	.reset      (reset),
	.sam_clk_en (sam_clk_en),
	.y          (y)
);

// File: test/pulseShaper_vectors.txt
# op gap sample expected_y, one step per line
# op 1 strobes the sample in, op 0 pulses reset, gap -1 draws 0 to 5 idle cycles
@ reset
0 0 0 0
1 0 0 0
1 1 65536 0
1 0 32770 0
1 3 -98306 0
1 0 131071 0
@ impulse_p32768
1 0 32768 0
1 0 0 0
1 0 0 0
1 0 0 0
1 0 0 0
1 0 0 911
1 0 0 872
1 0 0 215
1 0 0 -790
1 0 0 -1570
1 0 0 -1498
1 0 0 -227
1 0 0 2090
1 0 0 4788
1 0 0 6945
1 0 0 7767
1 0 0 6945
1 0 0 4788
1 0 0 2090
1 0 0 -227
1 0 0 -1498
1 0 0 -1570
@ impulse_m98303
1 0 -98303 -790
1 0 0 215
1 0 0 872
1 0 0 911
1 0 0 0
1 0 0 -2732
1 0 0 -2616
1 0 0 -646
1 0 0 2371
1 0 0 4709
1 0 0 4495
1 0 0 680
1 0 0 -6270
1 0 0 -14364
1 0 0 -20834
1 0 0 -23301
1 0 0 -20834
1 0 0 -14364
1 0 0 -6270
1 0 0 680
1 0 0 4495
1 0 0 4709
@ impulse_m32768
1 0 -32768 2371
1 0 0 -646
1 0 0 -2616
1 0 0 -2732
1 0 0 0
1 0 0 -911
1 0 0 -872
1 0 0 -215
1 0 0 790
1 0 0 1570
1 0 0 1498
1 0 0 227
1 0 0 -2090
1 0 0 -4788
1 0 0 -6945
1 0 0 -7767
1 0 0 -6945
1 0 0 -4788
1 0 0 -2090
1 0 0 227
1 0 0 1498
1 0 0 1570
@ impulse_p98303
1 0 98303 790
1 0 0 -215
1 0 0 -872
1 0 0 -911
1 0 0 0
1 0 0 2732
1 0 0 2616
1 0 0 646
1 0 0 -2371
1 0 0 -4709
1 0 0 -4495
1 0 0 -680
1 0 0 6270
1 0 0 14364
1 0 0 20834
1 0 0 23301
1 0 0 20834
1 0 0 14364
1 0 0 6270
1 0 0 -680
1 0 0 -4495
1 0 0 -4709
1 0 0 -2371
1 0 0 646
1 0 0 2616
1 0 0 2732
1 0 0 0
@ tolerance
1 0 32769 0
1 0 32770 0
1 0 -32770 0
1 0 -98304 0
1 0 -98301 0
1 0 65536 911
1 0 -32767 872
1 0 98305 215
1 0 -65536 -3522
1 0 98302 -4186
1 0 32766 -2144
1 0 0 1233
@ random_gaps
1 -1 98303 5927
1 -1 0 9068
1 -1 -32768 11147
1 -1 32768 5683
1 -1 0 -5275
1 -1 -98303 -15458
1 -1 0 -25394
1 -1 0 -30609
1 -1 0 -25819
1 -1 0 -13389
1 -1 0 1087
1 -1 0 18240
1 -1 0 32344
@ reset_midstream
0 2 0 0
1 0 98303 0
1 0 32768 0
1 -1 0 0
1 -1 0 0
1 -1 0 0
1 0 0 2732
1 0 0 3527
1 -1 0 1518
1 0 0 -2156
1 -1 0 -5499
